// File: hdl/usb_dfu_pkg.sv
package usb_dfu_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  dev_addr_t;
  typedef logic [15:0] xfr_len_t;
  typedef logic [7:0]  rom_addr_t;

  localparam int        SETUP_BYTES     = 8;
  localparam byte_t     MAX_PACKET_SIZE = 8'd32;

  // board identity
  localparam logic [15:0] BOARD_VID = 16'h1d50;
  localparam logic [15:0] BOARD_PID = 16'h6130;

  localparam logic [15:0] DFU_DETACH_TIMEOUT_MS = 16'd1000;
  localparam logic [15:0] DFU_TRANSFER_SIZE     = 16'd256;

  // reply source layout
  localparam rom_addr_t DEVICE_DESC_ADDR = 8'd0;
  localparam xfr_len_t  DEVICE_DESC_LEN  = 16'd18;
  localparam rom_addr_t CONFIG_DESC_ADDR = 8'd18;
  localparam xfr_len_t  CONFIG_TOTAL_LEN = 16'd27;
  localparam xfr_len_t  DFU_STATUS_LEN   = 16'd6;
  localparam rom_addr_t DFU_STATE_OFFSET = 8'd4;  // bState within the status block

  localparam byte_t DFU_STATE_APP_IDLE   = 8'd0;
  localparam byte_t DFU_STATE_APP_DETACH = 8'd1;

  // {bmRequestType[6:5], bRequest}
  localparam logic [9:0] REQ_GET_DESCRIPTOR    = 10'h006;
  localparam logic [9:0] REQ_SET_ADDRESS       = 10'h005;
  localparam logic [9:0] REQ_SET_CONFIGURATION = 10'h009;
  localparam logic [9:0] REQ_SET_INTERFACE     = 10'h00b;
  localparam logic [9:0] REQ_DFU_DETACH        = 10'h100;
  localparam logic [9:0] REQ_DFU_GETSTATUS     = 10'h103;
  localparam logic [9:0] REQ_DFU_CLRSTATUS     = 10'h104;
  localparam logic [9:0] REQ_DFU_GETSTATE      = 10'h105;
  localparam logic [9:0] REQ_DFU_ABORT         = 10'h106;

  ////////////////////////////////////////////////////////////
  // structs and enums
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    byte_t    bm_request_type;
    byte_t    b_request;
    xfr_len_t w_value;
    xfr_len_t w_index;
    xfr_len_t w_length;
  } setup_pkt_t;

  typedef enum logic {desc_rom, dfu_state} reply_src_e;

  typedef struct packed {
    reply_src_e src;
    rom_addr_t  start;
    xfr_len_t   length;
    logic       stall;
  } reply_plan_t;

  typedef struct packed {
    logic detach;
    logic clear_status;
    logic abort;
  } dfu_cmd_t;

  typedef enum logic [2:0] {
    idle,
    setup_in,
    setup_done,
    data_in,
    data_out,
    status_in,
    status_out
  } ctrl_stage_e;

  typedef struct packed {
    logic  data_avail;
    logic  setup;
    logic  grant;
    logic  acked;
    byte_t data;
  } out_ep_in_t;

  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_in_t;

  typedef struct packed {
    logic  req;
    logic  put;
    logic  done;
    logic  stall;
    byte_t data;
  } in_ep_out_t;

endpackage

// File: hdl/descriptor_rom.sv
`timescale 1ns/1ns

module descriptor_rom (
  input  usb_dfu_pkg::rom_addr_t addr,
  output usb_dfu_pkg::byte_t     data
);

  always_comb begin
    case (addr)
      // device descriptor
      8'd0:  data = 8'd18;
      8'd1:  data = 8'd1;
      8'd2:  data = 8'h00;  // usb 1.0
      8'd3:  data = 8'h01;
      8'd4:  data = 8'd0;   // class per interface
      8'd5:  data = 8'd0;
      8'd6:  data = 8'd0;
      8'd7:  data = usb_dfu_pkg::MAX_PACKET_SIZE;
      8'd8:  data = usb_dfu_pkg::BOARD_VID[7:0];
      8'd9:  data = usb_dfu_pkg::BOARD_VID[15:8];
      8'd10: data = usb_dfu_pkg::BOARD_PID[7:0];
      8'd11: data = usb_dfu_pkg::BOARD_PID[15:8];
      8'd12: data = 8'd0;
      8'd13: data = 8'd0;
      8'd14: data = 8'd1;   // string indices
      8'd15: data = 8'd2;
      8'd16: data = 8'd3;
      8'd17: data = 8'd1;   // one configuration
      // configuration descriptor
      8'd18: data = 8'd9;
      8'd19: data = 8'd2;
      8'd20: data = usb_dfu_pkg::CONFIG_TOTAL_LEN[7:0];
      8'd21: data = usb_dfu_pkg::CONFIG_TOTAL_LEN[15:8];
      8'd22: data = 8'd1;
      8'd23: data = 8'd1;
      8'd24: data = 8'd0;
      8'd25: data = 8'hc0;  // self powered
      8'd26: data = 8'd50;
      // interface, dfu runtime
      8'd27: data = 8'd9;
      8'd28: data = 8'd4;
      8'd29: data = 8'd0;
      8'd30: data = 8'd0;
      8'd31: data = 8'd0;
      8'd32: data = 8'hfe;  // application specific
      8'd33: data = 8'd1;
      8'd34: data = 8'd1;
      8'd35: data = 8'd4;
      // dfu functional descriptor
      8'd36: data = 8'd9;
      8'd37: data = 8'h21;
      8'd38: data = 8'h0f;
      8'd39: data = usb_dfu_pkg::DFU_DETACH_TIMEOUT_MS[7:0];
      8'd40: data = usb_dfu_pkg::DFU_DETACH_TIMEOUT_MS[15:8];
      8'd41: data = usb_dfu_pkg::DFU_TRANSFER_SIZE[7:0];
      8'd42: data = usb_dfu_pkg::DFU_TRANSFER_SIZE[15:8];
      8'd43: data = 8'h10;  // dfu 1.1
      8'd44: data = 8'h01;
      default: data = 8'h00;
    endcase
  end

endmodule

// File: hdl/dfu_runtime_state.sv
`timescale 1ns/1ns

module dfu_runtime_state #(
  parameter int ms_tick_cycles = 48000
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   usb_reset,
  input  usb_dfu_pkg::dfu_cmd_t  dfu_cmd,
  input  usb_dfu_pkg::rom_addr_t addr,
  output usb_dfu_pkg::byte_t     data,
  output logic                   dfu_detach
);

  // bStatus, bwPollTimeout[3], bState, iString
  usb_dfu_pkg::byte_t                status_mem [usb_dfu_pkg::DFU_STATUS_LEN];
  usb_dfu_pkg::byte_t                b_state;
  logic [$clog2(ms_tick_cycles)-1:0] presc;
  logic                              ms_tick;
  logic [15:0]                       detach_timer;

  assign b_state = status_mem[usb_dfu_pkg::DFU_STATE_OFFSET[2:0]];
  assign data    = (addr < usb_dfu_pkg::rom_addr_t'(usb_dfu_pkg::DFU_STATUS_LEN)) ?
                   status_mem[addr[2:0]] : 8'h00;

  always_ff @(posedge clk) begin
    if (reset) begin
      status_mem <= '{8'h00, 8'h01, 8'h00, 8'h00, usb_dfu_pkg::DFU_STATE_APP_IDLE, 8'h00};
    end else if (dfu_cmd.detach) begin
      status_mem[usb_dfu_pkg::DFU_STATE_OFFSET[2:0]] <= usb_dfu_pkg::DFU_STATE_APP_DETACH;
    end else if (dfu_cmd.clear_status) begin
      status_mem[0] <= 8'h00;  // status ok
      status_mem[usb_dfu_pkg::DFU_STATE_OFFSET[2:0]] <= usb_dfu_pkg::DFU_STATE_APP_IDLE;
    end else if (dfu_cmd.abort) begin
      status_mem[usb_dfu_pkg::DFU_STATE_OFFSET[2:0]] <= usb_dfu_pkg::DFU_STATE_APP_IDLE;
    end
  end

  ////////////////////////////////////////////////////////////
  // millisecond tick and detach timer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      presc        <= '0;
      ms_tick      <= 1'b0;
      detach_timer <= usb_dfu_pkg::DFU_DETACH_TIMEOUT_MS;
      dfu_detach   <= 1'b0;
    end else begin
      ms_tick <= 1'b0;
      if (presc == $bits(presc)'(ms_tick_cycles - 1)) begin
        presc   <= '0;
        ms_tick <= 1'b1;
      end else begin
        presc <= presc + $bits(presc)'(1);
      end

      if (dfu_cmd.detach) begin
        detach_timer <= usb_dfu_pkg::DFU_DETACH_TIMEOUT_MS;  // fresh timeout per request
      end else if (ms_tick && b_state == usb_dfu_pkg::DFU_STATE_APP_DETACH) begin
        if (detach_timer != '0) begin
          detach_timer <= detach_timer - 16'd1;
        end else begin
          dfu_detach <= 1'b1;
        end
      end

      // bus reset outside app_idle also leaves for the bootloader
      if (ms_tick && usb_reset && b_state != usb_dfu_pkg::DFU_STATE_APP_IDLE) begin
        dfu_detach <= 1'b1;
      end
    end
  end

endmodule

// File: hdl/setup_capture.sv
`timescale 1ns/1ns

module setup_capture (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::out_ep_in_t out_ep,
  input  logic                    status_done,
  output logic                    setup_start,
  output logic                    pkt_end,
  output usb_dfu_pkg::setup_pkt_t setup
);

  logic               avail_q;
  logic               data_valid;  // byte on out_ep.data this cycle
  logic               store;
  logic [3:0]         byte_idx;
  usb_dfu_pkg::byte_t setup_mem [usb_dfu_pkg::SETUP_BYTES];

  assign setup_start = out_ep.data_avail && !avail_q && out_ep.setup;
  assign pkt_end     = !out_ep.data_avail && avail_q;
  assign store       = out_ep.setup && data_valid &&
                       (byte_idx < 4'(usb_dfu_pkg::SETUP_BYTES));

  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q    <= 1'b0;
      data_valid <= 1'b0;
      byte_idx   <= '0;
    end else begin
      avail_q    <= out_ep.data_avail;
      data_valid <= out_ep.data_avail && out_ep.grant;  // data follows a cycle later
      if (status_done) begin
        byte_idx <= '0;
      end else if (store) begin
        byte_idx <= byte_idx + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      setup_mem[byte_idx[2:0]] <= out_ep.data;
    end
  end

  // wire fields are little endian on the bus
  always_comb begin
    setup.bm_request_type = setup_mem[0];
    setup.b_request       = setup_mem[1];
    setup.w_value         = {setup_mem[3], setup_mem[2]};
    setup.w_index         = {setup_mem[5], setup_mem[4]};
    setup.w_length        = {setup_mem[7], setup_mem[6]};
  end

endmodule

// File: hdl/request_decoder.sv
`timescale 1ns/1ns

module request_decoder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     setup_done,
  input  logic                     status_done,
  input  usb_dfu_pkg::setup_pkt_t  setup,
  output usb_dfu_pkg::reply_plan_t plan,
  output usb_dfu_pkg::dfu_cmd_t    dfu_cmd,
  output usb_dfu_pkg::dev_addr_t   dev_addr
);

  logic [9:0]             req_code;
  logic                   addr_pending;
  usb_dfu_pkg::dev_addr_t new_addr;

  assign req_code = {setup.bm_request_type[6:5], setup.b_request};

  always_ff @(posedge clk) begin
    if (reset) begin
      plan         <= '0;
      dfu_cmd      <= '0;
      addr_pending <= 1'b0;
      dev_addr     <= '0;
    end else begin
      dfu_cmd <= '0;  // commands are single cycle

      if (setup_done) begin
        // default is an ack with no data
        plan <= '{src: usb_dfu_pkg::desc_rom, start: '0, length: '0, stall: 1'b0};

        case (req_code)
          usb_dfu_pkg::REQ_GET_DESCRIPTOR: begin
            case (setup.w_value[15:8])
              8'd1: begin  // device
                plan.start  <= usb_dfu_pkg::DEVICE_DESC_ADDR;
                plan.length <= usb_dfu_pkg::DEVICE_DESC_LEN;
              end
              8'd2: begin  // configuration, whole set
                plan.start  <= usb_dfu_pkg::CONFIG_DESC_ADDR;
                plan.length <= usb_dfu_pkg::CONFIG_TOTAL_LEN;
              end
              default: plan.stall <= 1'b1;  // strings, qualifier etc
            endcase
          end

          usb_dfu_pkg::REQ_SET_ADDRESS: begin
            // status stage still runs on the old address
            addr_pending <= 1'b1;
            new_addr     <= setup.w_value[6:0];
          end

          usb_dfu_pkg::REQ_SET_CONFIGURATION,
          usb_dfu_pkg::REQ_SET_INTERFACE: ;  // single config, nothing to switch

          usb_dfu_pkg::REQ_DFU_DETACH:    dfu_cmd.detach       <= 1'b1;
          usb_dfu_pkg::REQ_DFU_CLRSTATUS: dfu_cmd.clear_status <= 1'b1;
          usb_dfu_pkg::REQ_DFU_ABORT:     dfu_cmd.abort        <= 1'b1;

          usb_dfu_pkg::REQ_DFU_GETSTATUS: begin
            plan.src    <= usb_dfu_pkg::dfu_state;
            plan.length <= usb_dfu_pkg::DFU_STATUS_LEN;
          end

          usb_dfu_pkg::REQ_DFU_GETSTATE: begin
            plan.src    <= usb_dfu_pkg::dfu_state;
            plan.start  <= usb_dfu_pkg::DFU_STATE_OFFSET;
            plan.length <= 16'd1;
          end

          default: ;
        endcase
      end

      if (status_done && addr_pending) begin
        addr_pending <= 1'b0;
        dev_addr     <= new_addr;
      end
    end
  end

endmodule

// File: hdl/ctrl_xfr_seq.sv
`timescale 1ns/1ns

module ctrl_xfr_seq (
  input  logic                     clk,
  input  logic                     reset,
  input  usb_dfu_pkg::out_ep_in_t  out_ep,
  input  logic                     setup_start,
  input  logic                     pkt_end,
  input  usb_dfu_pkg::setup_pkt_t  setup,
  input  usb_dfu_pkg::reply_plan_t plan,
  input  usb_dfu_pkg::in_ep_in_t   in_ep,
  output usb_dfu_pkg::in_ep_out_t  in_ep_o,
  output logic                     setup_done,
  output logic                     status_done,
  output usb_dfu_pkg::rom_addr_t   rd_addr,
  input  usb_dfu_pkg::byte_t       rom_data,
  input  usb_dfu_pkg::byte_t       dfu_data
);

  usb_dfu_pkg::ctrl_stage_e stage;
  usb_dfu_pkg::ctrl_stage_e stage_next;
  usb_dfu_pkg::xfr_len_t    remaining;
  usb_dfu_pkg::xfr_len_t    min_len;
  logic                     first;   // plan registered, counters not yet loaded
  logic                     done_q;
  logic                     zlp;
  logic                     accept;
  logic                     out_get;

  assign setup_done = (stage == usb_dfu_pkg::setup_done);
  assign min_len    = (setup.w_length < plan.length) ? setup.w_length : plan.length;
  assign accept     = in_ep_o.put && in_ep.grant;
  assign out_get    = (stage == usb_dfu_pkg::data_out) && out_ep.data_avail &&
                      out_ep.grant && !out_ep.setup;

  ////////////////////////////////////////////////////////////
  // stage FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    stage_next  = stage;
    zlp         = 1'b0;
    status_done = 1'b0;
    case (stage)
      usb_dfu_pkg::idle:
        if (setup_start) stage_next = usb_dfu_pkg::setup_in;
      usb_dfu_pkg::setup_in:
        if (pkt_end) stage_next = usb_dfu_pkg::setup_done;
      usb_dfu_pkg::setup_done: begin
        if (setup.w_length != '0) begin
          stage_next = setup.bm_request_type[7] ? usb_dfu_pkg::data_in
                                                : usb_dfu_pkg::data_out;
        end else begin
          stage_next = usb_dfu_pkg::status_in;
          zlp        = 1'b1;
        end
      end
      usb_dfu_pkg::data_in: begin
        if (first && plan.stall) begin
          stage_next  = usb_dfu_pkg::idle;
          status_done = 1'b1;  // no status stage after a stall
        end else if (!first && remaining == '0 && in_ep.acked) begin
          stage_next = usb_dfu_pkg::status_out;
        end
      end
      usb_dfu_pkg::data_out: begin
        if (remaining == '0) begin
          stage_next = usb_dfu_pkg::status_in;
          zlp        = 1'b1;
        end
      end
      usb_dfu_pkg::status_in: begin
        if (in_ep.acked) begin
          stage_next  = usb_dfu_pkg::idle;
          status_done = 1'b1;
        end
      end
      usb_dfu_pkg::status_out: begin
        if (out_ep.acked) begin
          stage_next  = usb_dfu_pkg::idle;
          status_done = 1'b1;
        end
      end
      default: stage_next = usb_dfu_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage     <= usb_dfu_pkg::idle;
      first     <= 1'b0;
      done_q    <= 1'b0;
      remaining <= '0;
      rd_addr   <= '0;
    end else begin
      stage  <= stage_next;
      first  <= setup_done;
      done_q <= 1'b0;
      if (setup_done) begin
        remaining <= setup.w_length;  // OUT stage counts the full request
      end else if (stage == usb_dfu_pkg::data_in && first) begin
        remaining <= min_len;
        rd_addr   <= plan.start;
        done_q    <= (min_len == '0) && !plan.stall;
      end else if (accept) begin
        remaining <= remaining - 16'd1;
        rd_addr   <= rd_addr + 8'd1;
        done_q    <= (remaining == 16'd1);  // last byte just went out
      end else if (out_get && remaining != '0) begin
        remaining <= remaining - 16'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // IN buffer side
  ////////////////////////////////////////////////////////////
  always_comb begin
    in_ep_o.req   = (stage == usb_dfu_pkg::data_in) && !first && (remaining != '0);
    in_ep_o.put   = in_ep_o.req && in_ep.data_free;
    in_ep_o.done  = done_q || zlp;
    in_ep_o.stall = (stage == usb_dfu_pkg::data_in) && first && plan.stall;
    in_ep_o.data  = (plan.src == usb_dfu_pkg::dfu_state) ? dfu_data : rom_data;
  end

endmodule

// File: hdl/usb_dfu_ctrl_ep.sv
`timescale 1ns/1ns

module usb_dfu_ctrl_ep #(
  parameter int ms_tick_cycles = 48000
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    usb_reset,
  input  usb_dfu_pkg::out_ep_in_t out_ep,
  output logic                    out_ep_req,
  output logic                    out_ep_data_get,
  input  usb_dfu_pkg::in_ep_in_t  in_ep,
  output usb_dfu_pkg::in_ep_out_t in_ep_o,
  output usb_dfu_pkg::dev_addr_t  dev_addr,
  output logic                    dfu_detach
);

  logic                     setup_start;
  logic                     pkt_end;
  logic                     setup_done;
  logic                     status_done;
  usb_dfu_pkg::setup_pkt_t  setup;
  usb_dfu_pkg::reply_plan_t plan;
  usb_dfu_pkg::dfu_cmd_t    dfu_cmd;
  usb_dfu_pkg::rom_addr_t   rd_addr;
  usb_dfu_pkg::byte_t       rom_data;
  usb_dfu_pkg::byte_t       dfu_data;

  // OUT buffer is drained whenever it holds bytes
  assign out_ep_req      = out_ep.data_avail;
  assign out_ep_data_get = out_ep.data_avail;

  setup_capture u_setup_capture (
    .clk         (clk),
    .reset       (reset),
    .out_ep      (out_ep),
    .status_done (status_done),
    .setup_start (setup_start),
    .pkt_end     (pkt_end),
    .setup       (setup)
  );

  request_decoder u_request_decoder (
    .clk         (clk),
    .reset       (reset),
    .setup_done  (setup_done),
    .status_done (status_done),
    .setup       (setup),
    .plan        (plan),
    .dfu_cmd     (dfu_cmd),
    .dev_addr    (dev_addr)
  );

  ctrl_xfr_seq u_ctrl_xfr_seq (
    .clk         (clk),
    .reset       (reset),
    .out_ep      (out_ep),
    .setup_start (setup_start),
    .pkt_end     (pkt_end),
    .setup       (setup),
    .plan        (plan),
    .in_ep       (in_ep),
    .in_ep_o     (in_ep_o),
    .setup_done  (setup_done),
    .status_done (status_done),
    .rd_addr     (rd_addr),
    .rom_data    (rom_data),
    .dfu_data    (dfu_data)
  );

  descriptor_rom u_descriptor_rom (
    .addr (rd_addr),
    .data (rom_data)
  );

  dfu_runtime_state #(
    .ms_tick_cycles (ms_tick_cycles)
  ) u_dfu_runtime_state (
    .clk        (clk),
    .reset      (reset),
    .usb_reset  (usb_reset),
    .dfu_cmd    (dfu_cmd),
    .addr       (rd_addr),
    .data       (dfu_data),
    .dfu_detach (dfu_detach)
  );

endmodule

// File: test/tb_usb_dfu_ctrl_ep.sv
`timescale 1ns/1ns

module tb_usb_dfu_ctrl_ep;

  localparam int TICK       = 4;   // clk cycles per ms tick
  localparam int DETACH_MS  = int'(usb_dfu_pkg::DFU_DETACH_TIMEOUT_MS);
  localparam int WAIT_LIMIT = 64;  // cycles allowed for any handshake

  logic                    clk;
  logic                    reset;
  logic                    usb_reset;
  usb_dfu_pkg::out_ep_in_t out_ep;
  logic                    out_ep_req;
  logic                    out_ep_data_get;
  usb_dfu_pkg::in_ep_in_t  in_ep;
  usb_dfu_pkg::in_ep_out_t in_ep_o;
  usb_dfu_pkg::dev_addr_t  dev_addr;
  logic                    dfu_detach;

  usb_dfu_pkg::byte_t rx_q [$];   // bytes taken from the IN buffer
  usb_dfu_pkg::byte_t exp_q [$];

  // reference descriptor set in ROM order
  usb_dfu_pkg::byte_t rom_exp [45] = '{
    8'd18, 8'd1, 8'h00, 8'h01, 8'd0, 8'd0, 8'd0, 8'd32,
    8'h50, 8'h1d,   // vid 1d50
    8'h30, 8'h61,   // pid 6130
    8'd0, 8'd0, 8'd1, 8'd2, 8'd3, 8'd1,
    8'd9, 8'd2, 8'd27, 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,   // configuration
    8'd9, 8'd4, 8'd0, 8'd0, 8'd0, 8'hfe, 8'd1, 8'd1, 8'd4,     // interface
    8'd9, 8'h21, 8'h0f, 8'he8, 8'h03, 8'h00, 8'h01, 8'h10, 8'h01  // dfu functional
  };

  usb_dfu_ctrl_ep #(
    .ms_tick_cycles (TICK)
  ) UUT (
    .clk             (clk),
    .reset           (reset),
    .usb_reset       (usb_reset),
    .out_ep          (out_ep),
    .out_ep_req      (out_ep_req),
    .out_ep_data_get (out_ep_data_get),
    .in_ep           (in_ep),
    .in_ep_o         (in_ep_o),
    .dev_addr        (dev_addr),
    .dfu_detach      (dfu_detach)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("error: time %0t %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout at %0t waiting for %s", $time, what);
    abort_run();
  endtask

  // OUT buffer requests follow data_avail
  task automatic verify_out_request(input logic avail);
    check_value("out_ep_req", int'(avail), int'(out_ep_req));
    check_value("out_ep_data_get", int'(avail), int'(out_ep_data_get));
  endtask

  ////////////////////////////////////////////////////////////
  // host side of the endpoint buffers
  ////////////////////////////////////////////////////////////
  task automatic apply_reset();
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  function automatic usb_dfu_pkg::setup_pkt_t make_setup(input logic [7:0] bm,
                                                         input logic [7:0] breq,
                                                         input logic [15:0] wv,
                                                         input logic [15:0] wl);
    usb_dfu_pkg::setup_pkt_t pkt;
    pkt.bm_request_type = bm;
    pkt.b_request       = breq;
    pkt.w_value         = wv;
    pkt.w_index         = 16'h0000;
    pkt.w_length        = wl;
    return pkt;
  endfunction

  task automatic send_setup(input usb_dfu_pkg::setup_pkt_t pkt);
    usb_dfu_pkg::byte_t wire_bytes [8];
    int k;
    wire_bytes[0] = pkt.bm_request_type;
    wire_bytes[1] = pkt.b_request;
    wire_bytes[2] = pkt.w_value[7:0];  // little endian on the wire
    wire_bytes[3] = pkt.w_value[15:8];
    wire_bytes[4] = pkt.w_index[7:0];
    wire_bytes[5] = pkt.w_index[15:8];
    wire_bytes[6] = pkt.w_length[7:0];
    wire_bytes[7] = pkt.w_length[15:8];
    @(posedge clk);
    out_ep.data_avail <= 1'b1;
    out_ep.setup      <= 1'b1;
    out_ep.grant      <= 1'b1;
    for (k = 0; k < 8; k++) begin
      @(negedge clk);
      verify_out_request(1'b1);
      @(posedge clk);
      out_ep.data <= wire_bytes[k];  // byte follows its grant by one cycle
      if (k == 7) begin
        out_ep.data_avail <= 1'b0;   // falling edge marks the packet end
        out_ep.grant      <= 1'b0;
      end
    end
    @(negedge clk);
    verify_out_request(1'b0);
    @(posedge clk);
    out_ep.setup <= 1'b0;
  endtask

  task automatic collect_in();
    int n;
    rx_q.delete();
    in_ep.grant     <= 1'b1;  // take every byte offered
    in_ep.data_free <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      assert (!in_ep_o.stall) else begin
        $display("unexpected stall on the IN endpoint at %0t", $time);
        abort_run();
      end
      if (in_ep_o.put && in_ep.grant) begin
        rx_q.push_back(in_ep_o.data);
      end
      n++;
      if (n > WAIT_LIMIT) timed_out("done after the IN data stage");
    end while (!in_ep_o.done);
    @(posedge clk);
    in_ep.acked     <= 1'b1;
    in_ep.grant     <= 1'b0;
    in_ep.data_free <= 1'b0;
    @(posedge clk);
    in_ep.acked <= 1'b0;
  endtask

  // in_stage picks which buffer acks the status packet
  task automatic finish_status(input logic in_stage);
    if (in_stage) begin
      in_ep.acked <= 1'b1;
    end else begin
      out_ep.acked <= 1'b1;
    end
    @(posedge clk);
    in_ep.acked  <= 1'b0;
    out_ep.acked <= 1'b0;
  endtask

  task automatic wait_zlp_done();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      assert (!in_ep_o.put && !in_ep_o.stall) else begin
        $display("data or stall on a request with no data stage at %0t", $time);
        abort_run();
      end
      n++;
      if (n > WAIT_LIMIT) timed_out("zero length done");
    end while (!in_ep_o.done);
    @(posedge clk);
  endtask

  task automatic in_request(input logic [7:0] bm, input logic [7:0] breq,
                            input logic [15:0] wv, input logic [15:0] wl);
    send_setup(make_setup(bm, breq, wv, wl));
    collect_in();
    finish_status(1'b0);
  endtask

  task automatic no_data_request(input logic [7:0] bm, input logic [7:0] breq,
                                 input logic [15:0] wv);
    send_setup(make_setup(bm, breq, wv, 16'd0));
    wait_zlp_done();
    finish_status(1'b1);
  endtask

  task automatic expect_rom(input int first, input int count);
    int i;
    exp_q.delete();
    for (i = first; i < first + count; i++) begin
      exp_q.push_back(rom_exp[i]);
    end
  endtask

  task automatic check_reply(input string name);
    int i;
    check_value({"reply length of ", name}, exp_q.size(), rx_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
      check_value($sformatf("in_ep_o.data[%0d] of %s", i, name),
                  int'(exp_q[i]), int'(rx_q[i]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic device_descriptor_read();
    expect_rom(0, 18);
    in_request(8'h80, 8'h06, 16'h0100, 16'd64);
    check_reply("device descriptor");
  endtask

  task automatic config_length_clamp();
    expect_rom(18, 9);
    in_request(8'h80, 8'h06, 16'h0200, 16'd9);
    check_reply("config descriptor, wLength 9");
    expect_rom(18, 27);  // whole set, shorter than the request
    in_request(8'h80, 8'h06, 16'h0200, 16'd255);
    check_reply("config descriptor, wLength 255");
  endtask

  task automatic set_address_deferred();
    int i;
    send_setup(make_setup(8'h00, 8'h05, 16'h002a, 16'd0));
    wait_zlp_done();
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      check_value("dev_addr", 0, int'(dev_addr));  // old address until status ack
    end
    @(posedge clk);
    finish_status(1'b1);
    @(negedge clk);
    check_value("dev_addr", 'h2a, int'(dev_addr));
    @(posedge clk);
  endtask

  task automatic dfu_request_sequence();
    exp_q.delete();
    exp_q.push_back(usb_dfu_pkg::DFU_STATE_APP_IDLE);
    in_request(8'ha1, 8'h05, 16'h0000, 16'd1);
    check_reply("GETSTATE before DETACH");
    no_data_request(8'h21, 8'h00, 16'd1000);
    exp_q.delete();
    exp_q.push_back(usb_dfu_pkg::DFU_STATE_APP_DETACH);
    in_request(8'ha1, 8'h05, 16'h0000, 16'd1);
    check_reply("GETSTATE after DETACH");
    // bStatus, poll timeout, bState, iString
    exp_q.delete();
    exp_q.push_back(8'h00);
    exp_q.push_back(8'h01);
    exp_q.push_back(8'h00);
    exp_q.push_back(8'h00);
    exp_q.push_back(usb_dfu_pkg::DFU_STATE_APP_DETACH);
    exp_q.push_back(8'h00);
    in_request(8'ha1, 8'h03, 16'h0000, 16'd6);
    check_reply("GETSTATUS");
    no_data_request(8'h21, 8'h04, 16'h0000);
    exp_q.delete();
    exp_q.push_back(usb_dfu_pkg::DFU_STATE_APP_IDLE);
    in_request(8'ha1, 8'h05, 16'h0000, 16'd1);
    check_reply("GETSTATE after CLRSTATUS");
  endtask

  task automatic detach_timing();
    int n;
    int seen_at;
    no_data_request(8'h21, 8'h00, 16'd1000);
    @(negedge clk);
    check_value("dfu_detach", 0, int'(dfu_detach));
    n = 0;
    while (!dfu_detach) begin
      @(negedge clk);
      n++;
      if (n > (DETACH_MS + 2) * TICK) timed_out("dfu_detach after DETACH");
    end
    assert (n >= (DETACH_MS - 1) * TICK) else begin
      $display("dfu_detach rose after only %0d cycles at %0t", n, $time);
      abort_run();
    end

    // bus reset while a detach is pending
    @(posedge clk);
    apply_reset();
    no_data_request(8'h21, 8'h00, 16'd1000);
    @(negedge clk);
    check_value("dfu_detach", 0, int'(dfu_detach));
    @(posedge clk);
    usb_reset <= 1'b1;
    seen_at = -1;
    for (n = 0; n < 3 * TICK; n++) begin
      @(negedge clk);
      if (dfu_detach && seen_at < 0) begin
        seen_at = n;
      end
    end
    @(posedge clk);
    usb_reset <= 1'b0;
    assert (seen_at >= 0 && seen_at < 2 * TICK) else begin
      $display("dfu_detach not raised within two ticks of usb_reset at %0t", $time);
      abort_run();
    end
  endtask

  task automatic string_descriptor_stall();
    int n;
    send_setup(make_setup(8'h80, 8'h06, 16'h0300, 16'd255));
    in_ep.grant     <= 1'b1;
    in_ep.data_free <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      check_value("in_ep_o.put", 0, int'(in_ep_o.put));
      n++;
      if (n > WAIT_LIMIT) timed_out("stall on a string descriptor request");
    end while (!in_ep_o.stall);
    // single stall cycle, then nothing until the next SETUP
    for (n = 0; n < 8; n++) begin
      @(negedge clk);
      check_value("in_ep_o.stall", 0, int'(in_ep_o.stall));
      check_value("in_ep_o.put", 0, int'(in_ep_o.put));
      check_value("in_ep_o.done", 0, int'(in_ep_o.done));
    end
    @(posedge clk);
    in_ep.grant     <= 1'b0;
    in_ep.data_free <= 1'b0;
    expect_rom(0, 18);
    in_request(8'h80, 8'h06, 16'h0100, 16'd64);
    check_reply("device descriptor after stall");
  endtask

  initial begin
    reset     <= 1'b1;
    usb_reset <= 1'b0;
    out_ep    <= '0;
    in_ep     <= '0;
    apply_reset();
    @(negedge clk);
    check_value("in_ep_o.req", 0, int'(in_ep_o.req));
    check_value("in_ep_o.done", 0, int'(in_ep_o.done));
    check_value("in_ep_o.stall", 0, int'(in_ep_o.stall));
    check_value("dev_addr", 0, int'(dev_addr));
    check_value("dfu_detach", 0, int'(dfu_detach));
    @(posedge clk);

    device_descriptor_read();
    config_length_clamp();
    set_address_deferred();
    dfu_request_sequence();
    detach_timing();
    string_descriptor_stall();

    $display("Test passed");
    $finish;
  end

endmodule

// File: usb_dfu_ctrl_ep.f
hdl/usb_dfu_pkg.sv
hdl/descriptor_rom.sv
hdl/dfu_runtime_state.sv
hdl/setup_capture.sv
hdl/request_decoder.sv
hdl/ctrl_xfr_seq.sv
hdl/usb_dfu_ctrl_ep.sv
test/tb_usb_dfu_ctrl_ep.sv

// File: run_sim.sh
#!/bin/sh
# build and run the control endpoint testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_usb_dfu_ctrl_ep \
  --Mdir obj_dir \
  -f usb_dfu_ctrl_ep.f

./obj_dir/Vtb_usb_dfu_ctrl_ep
